// File: heapPkg.sv
// Shared sizes, element and row types
// Opcode and error encodings of the array heap
`default_nettype none

package heapPkg;

  localparam int addressBits = 3;                  // Bits in an array number
  localparam int indexBits   = 3;                  // Bits in an element index
  localparam int dataBits    = 16;                 // Bits in one element
  localparam int arrays      = 2 ** addressBits;   // Arrays in the heap
  localparam int arrayLength = 2 ** indexBits;     // Elements per array

  typedef logic [addressBits-1:0] arrayNumber;     // Array number
  typedef logic [indexBits-1:0]   elementIndex;    // Position inside an array
  typedef logic [indexBits:0]     arraySize;       // Zero up to arrayLength
  typedef logic [dataBits-1:0]    element;         // One data word
  typedef element [arrayLength-1:0] row;           // Whole array, element 0 lowest

  //--------------------------------------------------------------------------
  // Request opcodes
  typedef enum logic [4:0] {
    opAlloc,                                       // New array, returns its number
    opFree,                                        // Give an array back
    opWrite,                                       // Store, may extend the size
    opRead,
    opSize,
    opPush,
    opPop,
    opAdd,
    opAddAfter,                                    // Returns the old value
    opSubtract,
    opSubAfter,                                    // Returns the old value
    opShiftLeft,
    opShiftRight,
    opNotLogical,
    opNot,
    opOr,
    opXor,
    opAnd,
    opIndex,                                       // Last match plus one
    opLess,
    opGreater                                      // Highest legal value
  } heapOpcode;

  // Request outcome
  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                               // Never allocated or freed
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory,
    errBadOpcode
  } heapError;

endpackage

`default_nettype wire

// File: elementAlu.sv
// Arithmetic and logic on one heap element
`timescale 1ns/1ns
`default_nettype none

module elementAlu (
  input  heapPkg::heapOpcode opcode,
  input  heapPkg::element    operand,    // Current element
  input  heapPkg::element    dataIn,
  output heapPkg::element    aluResult   // Value to store
);

  always_comb begin
    case (opcode)
      heapPkg::opAdd, heapPkg::opAddAfter: begin
        aluResult = operand + dataIn;    // Wraps at dataBits
      end
      heapPkg::opSubtract, heapPkg::opSubAfter: begin
        aluResult = operand - dataIn;
      end
      heapPkg::opShiftLeft: begin
        aluResult = operand << dataIn;   // Amount of dataBits or more gives 0
      end
      heapPkg::opShiftRight: begin
        aluResult = operand >> dataIn;
      end
      heapPkg::opNotLogical: begin
        aluResult = heapPkg::element'(operand == '0);
      end
      heapPkg::opNot: aluResult = ~operand;
      heapPkg::opOr:  aluResult = operand | dataIn;
      heapPkg::opXor: aluResult = operand ^ dataIn;
      heapPkg::opAnd: aluResult = operand & dataIn;
      default:        aluResult = operand;   // Not an element op
    endcase
  end

endmodule

`default_nettype wire

// File: rowSearch.sv
// Parallel search over the live part of a row
// Last match plus one, less and greater counts
`timescale 1ns/1ns
`default_nettype none

module rowSearch (
  input  heapPkg::row       searchRow,
  input  heapPkg::arraySize size,         // Live positions
  input  heapPkg::element   key,
  output heapPkg::arraySize matchIndex,   // 0 when nothing matches
  output heapPkg::arraySize lessCount,
  output heapPkg::arraySize greaterCount
);

  always_comb begin
    matchIndex   = '0;
    lessCount    = '0;
    greaterCount = '0;
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      if (heapPkg::arraySize'(i) < size) begin
        if (searchRow[i] == key) begin
          matchIndex = heapPkg::arraySize'(i + 1);   // Highest match wins
        end
        if (searchRow[i] < key) begin
          lessCount = lessCount + 1'b1;
        end
        if (searchRow[i] > key) begin
          greaterCount = greaterCount + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rowStore.sv
// Element memory of all arrays
// Registered whole row read, single element write
`timescale 1ns/1ns
`default_nettype none

module rowStore (
  input  logic                 clock,
  input  heapPkg::arrayNumber  readArray,
  input  logic                 readStrobe,   // Accepting edge
  input  logic                 writeEnable,
  input  heapPkg::arrayNumber  writeArray,
  input  heapPkg::elementIndex writeIndex,
  input  heapPkg::element      writeData,
  output heapPkg::row          readRow
);

  heapPkg::row rows [heapPkg::arrays];       // One row per array

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      rows[writeArray][writeIndex] <= writeData;
    end
    if (readStrobe) begin
      readRow <= rows[readArray];            // Held for the work cycle
    end
  end

endmodule

`default_nettype wire

// File: arrayDirectory.sv
// Array sizes and allocation flags
// LIFO free stack and high-water count for allocation
`timescale 1ns/1ns
`default_nettype none

module arrayDirectory (
  input  logic                clock,
  input  logic                reset,
  input  heapPkg::arrayNumber readArray,
  input  logic                readStrobe,
  input  logic                sizeEnable,
  input  heapPkg::arrayNumber sizeArray,
  input  heapPkg::arraySize   newSize,
  input  logic                allocate,
  input  logic                freeArray,
  input  heapPkg::arrayNumber freeNumber,
  output heapPkg::arraySize   readSize,
  output logic                readAllocated,
  output logic                freeAvailable,
  output logic                spaceAvailable,
  output heapPkg::arrayNumber allocNumber
);

  heapPkg::arraySize             sizes     [heapPkg::arrays];
  logic                          allocated [heapPkg::arrays];
  heapPkg::arrayNumber           freeStack [heapPkg::arrays];   // Freed numbers
  logic [heapPkg::addressBits:0] freeTop;                       // Entries on the stack
  logic [heapPkg::addressBits:0] highWater;                     // Numbers ever handed out
  heapPkg::arrayNumber           topIndex;

  assign topIndex       = heapPkg::arrayNumber'(freeTop - 1'b1);
  assign freeAvailable  = freeTop != '0;
  assign spaceAvailable = highWater < heapPkg::arrays;
  assign allocNumber    = freeAvailable ? freeStack[topIndex]   // Reuse before new
                                        : heapPkg::arrayNumber'(highWater);

  always_ff @(posedge clock) begin
    if (reset) begin
      freeTop   <= '0;
      highWater <= '0;
      for (int i = 0; i < heapPkg::arrays; i++) begin
        sizes[i]     <= '0;
        allocated[i] <= 1'b0;
      end
    end else begin
      if (sizeEnable) begin
        sizes[sizeArray] <= newSize;
      end
      if (allocate) begin
        allocated[allocNumber] <= 1'b1;
        sizes[allocNumber]     <= '0;      // Fresh array is empty
        if (freeAvailable) begin
          freeTop <= freeTop - 1'b1;
        end else begin
          highWater <= highWater + 1'b1;
        end
      end
      if (freeArray) begin
        allocated[freeNumber] <= 1'b0;
        freeTop               <= freeTop + 1'b1;
      end
    end
  end

  // Stack storage and read port
  always_ff @(posedge clock) begin
    if (freeArray) begin
      freeStack[heapPkg::arrayNumber'(freeTop)] <= freeNumber;
    end
    if (readStrobe) begin
      readSize      <= sizes[readArray];
      readAllocated <= allocated[readArray];
    end
  end

  //--------------------------------------------------------------------------
  allocWithSpace: assert property (@(posedge clock) disable iff (reset)
    allocate |-> freeAvailable || spaceAvailable);
  stackNoOverflow: assert property (@(posedge clock) disable iff (reset)
    freeArray |-> freeTop < heapPkg::arrays);

endmodule

`default_nettype wire

// File: heapControl.sv
// Request register and two cycle sequence of the heap
// Legality checks, write selection and result register
`timescale 1ns/1ns
`default_nettype none

module heapControl (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 start,
  input  heapPkg::heapOpcode   opcode,
  input  heapPkg::arrayNumber  array,
  input  heapPkg::elementIndex index,
  input  heapPkg::element      dataIn,
  input  heapPkg::row          readRow,
  input  heapPkg::arraySize    readSize,
  input  logic                 readAllocated,
  input  logic                 freeAvailable,
  input  logic                 spaceAvailable,
  input  heapPkg::arrayNumber  allocNumber,
  input  heapPkg::element      aluResult,
  input  heapPkg::arraySize    matchIndex,
  input  heapPkg::arraySize    lessCount,
  input  heapPkg::arraySize    greaterCount,
  output logic                 busy,
  output logic                 done,
  output heapPkg::element      dataOut,
  output heapPkg::heapError    error,
  output logic                 writeEnable,
  output heapPkg::arrayNumber  writeArray,
  output heapPkg::elementIndex writeIndex,
  output heapPkg::element      writeData,
  output logic                 sizeEnable,
  output heapPkg::arrayNumber  sizeArray,
  output heapPkg::arraySize    newSize,
  output logic                 allocate,
  output logic                 freeArray,
  output heapPkg::heapOpcode   heldOpcode,
  output heapPkg::element      heldElement,
  output heapPkg::element      heldData
);

  heapPkg::arrayNumber  heldArray;
  heapPkg::elementIndex heldIndex;
  heapPkg::heapError    nextError;        // Outcome of the held request
  heapPkg::element      nextData;         // Value for dataOut
  heapPkg::arraySize    indexPlusOne;
  heapPkg::elementIndex popIndex;         // Last live position
  logic                 accept;
  logic                 inBounds;
  logic                 loadData;
  logic                 wantWrite;
  logic                 wantSize;
  logic                 wantAlloc;
  logic                 wantFree;

  assign accept       = start && !busy;
  assign inBounds     = {1'b0, heldIndex} < readSize;
  assign indexPlusOne = {1'b0, heldIndex} + 1'b1;
  assign popIndex     = heapPkg::elementIndex'(readSize - 1'b1);
  assign heldElement  = readRow[heldIndex];
  assign writeArray   = heldArray;
  assign sizeArray    = heldArray;

  //--------------------------------------------------------------------------
  // Request capture and result
  always_ff @(posedge clock) begin
    if (accept) begin
      heldOpcode <= opcode;
      heldArray  <= array;
      heldIndex  <= index;
      heldData   <= dataIn;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      dataOut <= '0;
      error   <= heapPkg::errNone;
    end else begin
      busy <= accept;                     // Work cycle follows acceptance
      done <= busy;                       // Commit edge raises done
      if (busy) begin
        error <= nextError;
        if (loadData) begin
          dataOut <= nextData;            // Kept on error and free
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // Decode and legality checks
  always_comb begin
    nextError  = heapPkg::errNone;
    nextData   = heldData;
    writeIndex = heldIndex;
    writeData  = heldData;
    newSize    = readSize;
    loadData   = 1'b0;
    wantWrite  = 1'b0;
    wantSize   = 1'b0;
    wantAlloc  = 1'b0;
    wantFree   = 1'b0;
    if (heldOpcode > heapPkg::opGreater) begin
      nextError = heapPkg::errBadOpcode;  // Outside the enum
    end else if (heldOpcode != heapPkg::opAlloc && !readAllocated) begin
      nextError = heapPkg::errNotAllocated;
    end else begin
      case (heldOpcode)
        heapPkg::opAlloc: begin
          if (!freeAvailable && !spaceAvailable) begin
            nextError = heapPkg::errOutOfMemory;
          end else begin
            wantAlloc = 1'b1;
            loadData  = 1'b1;
            nextData  = heapPkg::element'(allocNumber);
          end
        end
        heapPkg::opFree: wantFree = 1'b1;
        heapPkg::opWrite: begin
          wantWrite = 1'b1;
          loadData  = 1'b1;
          if (indexPlusOne > readSize) begin
            wantSize = 1'b1;              // Grow to cover the index
            newSize  = indexPlusOne;
          end
        end
        heapPkg::opRead: begin
          if (!inBounds) begin
            nextError = heapPkg::errOutOfBounds;
          end else begin
            loadData = 1'b1;
            nextData = heldElement;
          end
        end
        heapPkg::opSize: begin
          loadData = 1'b1;
          nextData = heapPkg::element'(readSize);
        end
        heapPkg::opPush: begin
          if (readSize == heapPkg::arrayLength) begin
            nextError = heapPkg::errFull;
          end else begin
            wantWrite  = 1'b1;
            wantSize   = 1'b1;
            loadData   = 1'b1;
            writeIndex = heapPkg::elementIndex'(readSize);   // Append position
            newSize    = readSize + 1'b1;
          end
        end
        heapPkg::opPop: begin
          if (readSize == '0) begin
            nextError = heapPkg::errEmpty;
          end else begin
            wantSize = 1'b1;
            loadData = 1'b1;
            newSize  = readSize - 1'b1;
            nextData = readRow[popIndex];
          end
        end
        heapPkg::opIndex: begin
          loadData = 1'b1;
          nextData = heapPkg::element'(matchIndex);
        end
        heapPkg::opLess: begin
          loadData = 1'b1;
          nextData = heapPkg::element'(lessCount);
        end
        heapPkg::opGreater: begin
          loadData = 1'b1;
          nextData = heapPkg::element'(greaterCount);
        end
        heapPkg::opAdd, heapPkg::opAddAfter, heapPkg::opSubtract, heapPkg::opSubAfter,
        heapPkg::opShiftLeft, heapPkg::opShiftRight, heapPkg::opNotLogical, heapPkg::opNot,
        heapPkg::opOr, heapPkg::opXor, heapPkg::opAnd: begin
          if (!inBounds) begin
            nextError = heapPkg::errOutOfBounds;
          end else begin
            wantWrite = 1'b1;             // Element updated in place
            loadData  = 1'b1;
            writeData = aluResult;
            if (heldOpcode == heapPkg::opAddAfter || heldOpcode == heapPkg::opSubAfter) begin
              nextData = heldElement;     // Value before the update
            end else begin
              nextData = aluResult;
            end
          end
        end
        default: nextError = heapPkg::errBadOpcode;
      endcase
    end
  end

  assign writeEnable = busy && wantWrite; // Commit only on the work cycle
  assign sizeEnable  = busy && wantSize;
  assign allocate    = busy && wantAlloc;
  assign freeArray   = busy && wantFree;

  //--------------------------------------------------------------------------
  noStartWhileBusy: assert property (@(posedge clock) disable iff (reset) busy |-> !start);
  singleDone: assert property (@(posedge clock) disable iff (reset) done |=> !done);
  writeOnlyOnSuccess: assert property (@(posedge clock) disable iff (reset)
    writeEnable |=> error == heapPkg::errNone);

endmodule

`default_nettype wire

// File: heapMemory.sv
// Array heap top level
// Request control plus row store, directory, element ALU and search
`timescale 1ns/1ns
`default_nettype none

module heapMemory (
  input  logic                clock,
  input  logic                reset,
  input  logic                start,      // Request strobe
  input  heapPkg::heapOpcode  opcode,
  input  heapPkg::arrayNumber array,
  input  heapPkg::elementIndex index,
  input  heapPkg::element     dataIn,
  output logic                busy,
  output logic                done,       // One cycle per finished request
  output heapPkg::element     dataOut,
  output heapPkg::heapError   error
);

  heapPkg::row          readRow;          // Row of the request
  heapPkg::arraySize    readSize;
  logic                 readAllocated;
  logic                 freeAvailable;
  logic                 spaceAvailable;
  heapPkg::arrayNumber  allocNumber;      // Next number alloc hands out
  heapPkg::element      aluResult;
  heapPkg::arraySize    matchIndex;
  heapPkg::arraySize    lessCount;
  heapPkg::arraySize    greaterCount;
  logic                 writeEnable;      // Element commit
  heapPkg::arrayNumber  writeArray;
  heapPkg::elementIndex writeIndex;
  heapPkg::element      writeData;
  logic                 sizeEnable;       // Directory commit
  heapPkg::arrayNumber  sizeArray;
  heapPkg::arraySize    newSize;
  logic                 allocate;
  logic                 freeArray;
  heapPkg::heapOpcode   heldOpcode;
  heapPkg::element      heldElement;      // Addressed element before the op
  heapPkg::element      heldData;

  heapControl control (
    .clock, .reset, .start, .opcode, .array, .index, .dataIn,
    .readRow, .readSize, .readAllocated, .freeAvailable, .spaceAvailable,
    .allocNumber, .aluResult, .matchIndex, .lessCount, .greaterCount,
    .busy, .done, .dataOut, .error,
    .writeEnable, .writeArray, .writeIndex, .writeData,
    .sizeEnable, .sizeArray, .newSize, .allocate, .freeArray,
    .heldOpcode, .heldElement, .heldData
  );

  rowStore store (                        // Row read on the accepting edge
    .clock,
    .readArray  (array),
    .readStrobe (start && !busy),
    .writeEnable,
    .writeArray,
    .writeIndex,
    .writeData,
    .readRow
  );

  arrayDirectory directory (
    .clock,
    .reset,
    .readArray  (array),
    .readStrobe (start && !busy),
    .sizeEnable,
    .sizeArray,
    .newSize,
    .allocate,
    .freeArray,
    .freeNumber (sizeArray),              // Held array of the request
    .readSize,
    .readAllocated,
    .freeAvailable,
    .spaceAvailable,
    .allocNumber
  );

  elementAlu alu (
    .opcode  (heldOpcode),
    .operand (heldElement),
    .dataIn  (heldData),
    .aluResult
  );

  rowSearch search (
    .searchRow (readRow),
    .size      (readSize),
    .key       (heldData),
    .matchIndex,
    .lessCount,
    .greaterCount
  );

endmodule

`default_nettype wire

// File: tbClock.sv
// Free running testbench clock with a 4 ns period
`timescale 1ns/1ns
`default_nettype none

module tbClock (
  output logic clock
);

  initial clock = 1'b0;

  always #2 clock = ~clock;                // Half period

endmodule

`default_nettype wire

// File: heapModel.svh
// Reference model of the array heap for the testbench
// Model state plus prediction of dataOut and error per request
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

heapPkg::element   modelRows [heapPkg::arrays][heapPkg::arrayLength];
int                modelSizes [heapPkg::arrays] = '{default: 0};
bit                modelAllocated [heapPkg::arrays] = '{default: 1'b0};
int                modelFreeStack [$];            // Back of the queue is the top
int                modelHighWater = 0;
heapPkg::element   modelData = '0;                // Predicted dataOut
heapPkg::heapError modelError = heapPkg::errNone;

function automatic heapPkg::element elementResult(input int op, input heapPkg::element old,
                                                 input heapPkg::element data);
  case (op)
    heapPkg::opAdd, heapPkg::opAddAfter:      return old + data;   // Wraps at 16 bits
    heapPkg::opSubtract, heapPkg::opSubAfter: return old - data;
    heapPkg::opShiftLeft:  return (data >= heapPkg::dataBits) ? 16'd0 : old << data;
    heapPkg::opShiftRight: return (data >= heapPkg::dataBits) ? 16'd0 : old >> data;
    heapPkg::opNotLogical: return (old == 16'd0) ? 16'd1 : 16'd0;
    heapPkg::opNot:        return ~old;
    heapPkg::opOr:         return old | data;
    heapPkg::opXor:        return old ^ data;
    default:               return old & data;
  endcase
endfunction

function automatic heapPkg::element searchResult(input int op, input int arr,
                                                input heapPkg::element key);
  int found;
  int less;
  int greater;
  found = 0;
  less = 0;
  greater = 0;
  for (int i = 0; i < modelSizes[arr]; i++) begin   // Live part only
    if (modelRows[arr][i] == key) found = i + 1;
    if (modelRows[arr][i] < key) less++;
    if (modelRows[arr][i] > key) greater++;
  end
  if (op == heapPkg::opIndex) return heapPkg::element'(found);
  if (op == heapPkg::opLess) return heapPkg::element'(less);
  return heapPkg::element'(greater);
endfunction

function automatic void predictRequest(input int op, input int arr, input int idx,
                                       input heapPkg::element data);
  int size;
  int number;
  heapPkg::element fresh;
  size = modelSizes[arr];
  modelError = heapPkg::errNone;                  // modelData kept unless loaded
  if (op > heapPkg::opGreater) begin
    modelError = heapPkg::errBadOpcode;
  end else if (op == heapPkg::opAlloc) begin
    if (modelFreeStack.size() > 0) begin
      number = modelFreeStack.pop_back();         // Reuse newest freed number
    end else if (modelHighWater < heapPkg::arrays) begin
      number = modelHighWater;
      modelHighWater++;
    end else begin
      modelError = heapPkg::errOutOfMemory;
      return;
    end
    modelAllocated[number] = 1'b1;
    modelSizes[number] = 0;
    modelData = heapPkg::element'(number);
  end else if (!modelAllocated[arr]) begin
    modelError = heapPkg::errNotAllocated;
  end else if (op == heapPkg::opFree) begin
    modelAllocated[arr] = 1'b0;
    modelFreeStack.push_back(arr);
  end else if (op == heapPkg::opWrite) begin
    modelRows[arr][idx] = data;
    if (idx + 1 > size) modelSizes[arr] = idx + 1;
    modelData = data;
  end else if (op == heapPkg::opSize) begin
    modelData = heapPkg::element'(size);
  end else if (op == heapPkg::opPush) begin
    if (size == heapPkg::arrayLength) begin
      modelError = heapPkg::errFull;
    end else begin
      modelRows[arr][size] = data;
      modelSizes[arr] = size + 1;
      modelData = data;
    end
  end else if (op == heapPkg::opPop) begin
    if (size == 0) begin
      modelError = heapPkg::errEmpty;
    end else begin
      modelSizes[arr] = size - 1;
      modelData = modelRows[arr][size - 1];
    end
  end else if (op >= heapPkg::opIndex) begin
    modelData = searchResult(op, arr, data);
  end else if (idx >= size) begin
    modelError = heapPkg::errOutOfBounds;         // Read and element ops
  end else if (op == heapPkg::opRead) begin
    modelData = modelRows[arr][idx];
  end else begin
    fresh = elementResult(op, modelRows[arr][idx], data);
    if (op == heapPkg::opAddAfter || op == heapPkg::opSubAfter) modelData = modelRows[arr][idx];
    else modelData = fresh;
    modelRows[arr][idx] = fresh;
  end
endfunction

`endif

// File: heapMemoryTb.sv
// Testbench top of the array heap
// Directed and random requests, assertions against the reference model
`timescale 1ns/1ns
`default_nettype none

module heapMemoryTb;

  localparam int randomRequests   = 300;
  localparam int directedRequests = 130;   // Upper bound of the directed part
  localparam int timeoutCycles    = (directedRequests + randomRequests) * 3 + 210;

  logic                 clock;
  logic                 reset;
  logic                 start;
  heapPkg::heapOpcode   opcode;
  heapPkg::arrayNumber  array;
  heapPkg::elementIndex index;
  heapPkg::element      dataIn;
  logic                 busy;
  logic                 done;
  heapPkg::element      dataOut;
  heapPkg::heapError    error;
  heapPkg::element      expectedData;     // Checked on the next done
  heapPkg::heapError    expectedError;
  logic [31:0]          randomState;
  int                   cycleCount;

  `include "heapModel.svh"

  tbClock clockGen (.clock);

  heapMemory UUT (
    .clock, .reset, .start, .opcode, .array, .index, .dataIn,
    .busy, .done, .dataOut, .error
  );

  // --------------------------------------------------------------------------
  // Response checks
  dataCheck: assert property (@(posedge clock) disable iff (reset)
      done |-> dataOut == expectedData)
    else begin
      $display("** Error at %0t ns: dataOut expected %h, actual %h",
               $time, $sampled(expectedData), $sampled(dataOut));
      $display("TEST FAIL");
      $fatal(1);
    end

  errorCheck: assert property (@(posedge clock) disable iff (reset)
      done |-> error == expectedError)
    else begin
      $display("** Error at %0t ns: error expected %0d, actual %0d",
               $time, $sampled(expectedError), $sampled(error));
      $display("TEST FAIL");
      $fatal(1);
    end

  requestTiming: assert property (@(posedge clock) disable iff (reset)
      (start && !busy) |=> (busy && !done) ##1 (done && !busy))
    else begin
      $display("At %0t ns done did not come two cycles after the accepted start", $time);
      $display("TEST FAIL");
      $fatal(1);
    end

  always @(posedge clock) begin           // Watchdog
    cycleCount <= cycleCount + 1;
    if (cycleCount == timeoutCycles) begin
      $display("timeout, done never came");
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshiftNext();
    logic [31:0] x;
    x = randomState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    randomState = x;
    return x;
  endfunction

  function automatic int pickArray(input logic [31:0] r);
    int a;
    a = int'(r[2:0]);
    if (r[8:7] != 2'b00) begin            // Three in four toward a live array
      for (int j = 0; j < heapPkg::arrays; j++) begin
        if (modelAllocated[(a + j) % heapPkg::arrays]) return (a + j) % heapPkg::arrays;
      end
    end
    return a;
  endfunction

  // Called on a rising edge, returns on the edge after done
  task automatic runRequest(input logic [4:0] op, input int arr, input int idx,
                            input heapPkg::element data);
    predictRequest(int'(op), arr, idx, data);
    expectedData  <= modelData;
    expectedError <= modelError;
    start  <= 1'b1;
    opcode <= heapPkg::heapOpcode'(op);
    array  <= heapPkg::arrayNumber'(arr);
    index  <= heapPkg::elementIndex'(idx);
    dataIn <= data;
    @(posedge clock);
    start <= 1'b0;
    do @(posedge clock); while (!done);
  endtask

  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    heapPkg::heapOpcode arithOps [11];
    heapPkg::element arithData [11];
    arithOps = '{heapPkg::opAdd, heapPkg::opAddAfter,
      heapPkg::opSubtract, heapPkg::opSubAfter, heapPkg::opShiftLeft, heapPkg::opShiftRight,
      heapPkg::opNotLogical, heapPkg::opNot, heapPkg::opOr, heapPkg::opXor, heapPkg::opAnd};
    arithData = '{16'h1234, 16'h00ff, 16'h4321, 16'hffff, 16'd3,
      16'd5, 16'h0000, 16'h0000, 16'h0f0f, 16'haaaa, 16'h3c3c};
    reset         = 1'b1;
    start         = 1'b0;
    opcode        = heapPkg::opAlloc;
    array         = '0;
    index         = '0;
    dataIn        = '0;
    expectedData  = '0;
    expectedError = heapPkg::errNone;
    randomState   = 32'd39;
    cycleCount    = 0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    runRequest(heapPkg::opRead, 2, 0, 16'h0000);          // Never allocated
    runRequest(heapPkg::opWrite, 6, 1, 16'h1111);
    for (int a = 0; a <= heapPkg::arrays; a++) begin      // Last one out of memory
      runRequest(heapPkg::opAlloc, 0, 0, 16'h0000);
    end

    // Fill every row so no element is unknown
    for (int a = 0; a < heapPkg::arrays; a++) begin
      for (int i = 0; i < heapPkg::arrayLength; i++) begin
        r = xorshiftNext();
        runRequest(heapPkg::opPush, a, 0, r[15:0]);
      end
    end
    runRequest(heapPkg::opPush, 0, 0, 16'hdead);          // Full
    for (int i = 0; i <= heapPkg::arrayLength; i++) begin
      runRequest(heapPkg::opPop, 1, 0, 16'h0000);         // Ends on empty
    end

    // Free, freed access, double free, LIFO reuse
    runRequest(heapPkg::opFree, 3, 0, 16'h0000);
    runRequest(heapPkg::opFree, 5, 0, 16'h0000);
    runRequest(heapPkg::opRead, 3, 0, 16'h0000);
    runRequest(heapPkg::opFree, 5, 0, 16'h0000);
    runRequest(heapPkg::opAlloc, 0, 0, 16'h0000);
    runRequest(heapPkg::opAlloc, 0, 0, 16'h0000);

    runRequest(heapPkg::opWrite, 3, 5, 16'h5a5a);         // Size grows to 6
    runRequest(heapPkg::opSize, 3, 0, 16'h0000);
    runRequest(heapPkg::opRead, 3, 5, 16'h0000);
    runRequest(heapPkg::opRead, 3, 2, 16'h0000);
    runRequest(heapPkg::opRead, 3, 6, 16'h0000);          // Beyond size

    runRequest(heapPkg::opWrite, 0, 6, 16'h0000);         // Zero for logical not
    for (int k = 0; k < 11; k++) begin
      runRequest(arithOps[k], 0, k % heapPkg::arrayLength, arithData[k]);
      runRequest(heapPkg::opRead, 0, k % heapPkg::arrayLength, 16'h0000);
    end
    runRequest(heapPkg::opShiftLeft, 0, 3, 16'd20);       // Too far, gives 0
    runRequest(heapPkg::opRead, 0, 3, 16'h0000);

    runRequest(heapPkg::opWrite, 3, 1, 16'h5a5a);         // Earlier copy of the key
    runRequest(heapPkg::opIndex, 3, 0, 16'h5a5a);
    runRequest(heapPkg::opIndex, 3, 0, modelRows[3][7]);  // Stale, past the size
    runRequest(heapPkg::opLess, 3, 0, 16'h8000);
    runRequest(heapPkg::opGreater, 3, 0, 16'h8000);

    // --------------------------------------------------------------------------
    // Random requests including opcodes outside the enum
    for (int n = 0; n < randomRequests; n++) begin
      logic [4:0] op;
      int arr;
      int idx;
      heapPkg::element data;
      r = xorshiftNext();
      op = 5'(r % 24);
      arr = pickArray(xorshiftNext());
      r = xorshiftNext();
      idx = int'(r[2:0]);
      if (r[31]) data = modelRows[arr][r[5:3]];           // Likely search hit
      else if (r[30]) data = heapPkg::element'(r[8:6]);   // Small shift amount
      else data = r[23:8];
      runRequest(op, arr, idx, data);
    end

    @(posedge clock);                     // Let the last check run
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
heapPkg.sv
elementAlu.sv
rowSearch.sv
rowStore.sv
arrayDirectory.sv
heapControl.sv
heapMemory.sv
tbClock.sv
heapMemoryTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the heap testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module heapMemoryTb \
  -f sim.f -o heapSim

./obj_dir/heapSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0
